//--- Bender.yml
package:
  name: sd_link

sources:
  - verilog/sd_link_pkg.sv
  - verilog/sd_edge_sync.sv
  - verilog/sd_cmd_capture.sv
  - verilog/sd_cmd_exec.sv
  - verilog/sd_resp_builder.sv
  - verilog/sd_link.sv
  - target: simulation
    files:
      - verification/sd_link_tb.sv

//--- sources.f
verilog/sd_link_pkg.sv
verilog/sd_edge_sync.sv
verilog/sd_cmd_capture.sv
verilog/sd_cmd_exec.sv
verilog/sd_resp_builder.sv
verilog/sd_link.sv
verification/sd_link_tb.sv

//--- verification/sd_link_tb.sv
// testbench for the SD link: clock, reset, watchdog, compare tasks, directed tests and report
`timescale 1ns/1ns
module sd_link_tb;
   import sd_link_pkg::*;

   localparam int num_cmds        = 20;
   localparam int watchdog_cycles = num_cmds * 40 + 100;
   localparam int resp_timeout    = 30;
   localparam int quiet_cycles    = 24;

   logic                    clk_50;
   logic                    reset_s;
   logic [47:0]             phy_cmd_in;
   logic                    phy_cmd_in_crc_good;
   logic                    phy_cmd_in_act;
   logic                    phy_resp_done;
   logic [resp_frame_w-1:0] phy_resp_out;
   resp_kind_e              phy_resp_type;
   logic                    phy_resp_busy;
   logic                    phy_resp_act;
   logic                    phy_mode_4bit;
   card_state_e             link_card_state;
   logic [5:0]              cmd_in_last;
   logic                    err_cmd_crc;
   logic                    err_unhandled_cmd;
   integer                  seed;
   int                      mismatch_count;
   int                      failure_count;

   sd_link #(
      .acmd41_polls (3)
   ) uut (
      .clk_50              (clk_50),
      .reset_s             (reset_s),
      .phy_cmd_in          (phy_cmd_in),
      .phy_cmd_in_crc_good (phy_cmd_in_crc_good),
      .phy_cmd_in_act      (phy_cmd_in_act),
      .phy_resp_done       (phy_resp_done),
      .phy_resp_out        (phy_resp_out),
      .phy_resp_type       (phy_resp_type),
      .phy_resp_busy       (phy_resp_busy),
      .phy_resp_act        (phy_resp_act),
      .phy_mode_4bit       (phy_mode_4bit),
      .link_card_state     (link_card_state),
      .cmd_in_last         (cmd_in_last),
      .err_cmd_crc         (err_cmd_crc),
      .err_unhandled_cmd   (err_unhandled_cmd)
   );

   always #50 clk_50 = ~clk_50;

   task automatic check_kind(input resp_kind_e got, input resp_kind_e exp, input string msg);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s, kind %s, expected %s", $time, msg,
                  got.name(), exp.name());
         mismatch_count++;
      end
   endtask

   task automatic check_frame(input logic [resp_frame_w-1:0] got,
                              input logic [resp_frame_w-1:0] exp, input string msg);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s, frame %h, expected %h", $time, msg, got, exp);
         mismatch_count++;
      end
   endtask

   task automatic check_state(input card_state_e got, input card_state_e exp, input string msg);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s, state %s, expected %s", $time, msg,
                  got.name(), exp.name());
         mismatch_count++;
      end
   endtask

   task automatic check_index(input logic [5:0] got, input logic [5:0] exp, input string msg);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s, index %0d, expected %0d", $time, msg, got, exp);
         mismatch_count++;
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string msg);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s, got %b, expected %b", $time, msg, got, exp);
         mismatch_count++;
      end
   endtask

   // status as the card reports it with no error bits set
   function automatic logic [31:0] status_word(input card_state_e st, input logic app);
      return (32'd1 << stat_ready_for_data) | (32'(st) << 9) | (32'(app) << stat_app_cmd);
   endfunction

   // 48-bit response frames, left aligned in the 136-bit output
   function automatic logic [resp_frame_w-1:0] short_frame(input logic [5:0] idx,
                                                           input logic [31:0] body,
                                                           input logic [7:0] tail);
      return {2'b00, idx, body, tail, 88'h0};
   endfunction

   task automatic wait_cycle;
      @(posedge clk_50);
      #5;
   endtask

   task automatic send_cmd(input logic [5:0] index, input logic [31:0] arg, input logic crc_ok);
      // start, transmission bit, index, argument, crc7 left at zero, end bit
      phy_cmd_in          = {2'b01, index, arg, 7'h00, 1'b1};
      phy_cmd_in_crc_good = crc_ok;
      phy_cmd_in_act      = 1'b1;
      repeat (6) wait_cycle();
      phy_cmd_in_act      = 1'b0;
   endtask

   task automatic expect_resp(input resp_kind_e kind, input logic [resp_frame_w-1:0] frame,
                              input string msg, output logic [resp_frame_w-1:0] got);
      int          n;
      int          delay;
      logic [31:0] rnd;
      n   = 0;
      got = '0;
      while (!phy_resp_act && n < resp_timeout) begin
         wait_cycle();
         n++;
      end
      if (!phy_resp_act) begin
         $display("missing response at %0t ns: %s never raised phy_resp_act", $time, msg);
         failure_count++;
      end else begin
         got = phy_resp_out;
         check_kind(phy_resp_type, kind, msg);
         check_frame(phy_resp_out, frame, msg);
         check_bit(phy_resp_busy, kind == resp_r1b, {msg, " busy"});
         // phy takes a random time to shift the frame out
         rnd   = $random(seed);
         delay = rnd[2:0] + 1;
         repeat (delay) wait_cycle();
         phy_resp_done = 1'b1;
         n = 0;
         while (phy_resp_act && n < resp_timeout) begin
            wait_cycle();
            n++;
         end
         if (phy_resp_act) begin
            $display("handshake stuck at %0t ns: %s kept phy_resp_act high", $time, msg);
            failure_count++;
         end
         phy_resp_done = 1'b0;
         // execute commits the card state one cycle after act falls
         wait_cycle();
      end
   endtask

   task automatic expect_no_resp(input string msg);
      logic seen;
      seen = 1'b0;
      repeat (quiet_cycles) begin
         wait_cycle();
         if (phy_resp_act) begin
            seen = 1'b1;
         end
      end
      check_bit(seen, 1'b0, {msg, ", phy_resp_act raised"});
   endtask

   task automatic test_reset;
      check_bit(phy_resp_act, 1'b0, "reset act");
      check_bit(phy_mode_4bit, 1'b0, "reset bus width");
      check_bit(err_cmd_crc, 1'b0, "reset crc flag");
      check_bit(err_unhandled_cmd, 1'b0, "reset unhandled flag");
      check_state(link_card_state, card_idle, "reset state");
   endtask

   task automatic test_init;
      logic [resp_frame_w-1:0] got;
      logic [31:0]             ocr;
      logic [31:0]             sw;
      // voltage field 1, check pattern a5
      send_cmd(6'd8, 32'h0000_01a5, 1'b1);
      expect_resp(resp_r7, short_frame(6'd8, 32'h0000_01a5, 8'h01), "cmd8", got);
      check_index(cmd_in_last, 6'd8, "last index after cmd8");
      for (int i = 0; i < 4; i++) begin
         send_cmd(6'd55, 32'h0, 1'b1);
         expect_resp(resp_r1, short_frame(6'd55, status_word(card_idle, 1'b1), 8'h01),
                     "cmd55 in idle", got);
         // high capacity accepted, powered up only on the fourth poll
         ocr = {8'h40, ocr_voltage_window};
         if (i == 3) begin
            ocr[ocr_powered_up] = 1'b1;
         end
         send_cmd(6'd41, {8'h40, ocr_voltage_window}, 1'b1);
         expect_resp(resp_r3, short_frame(6'h3f, ocr, 8'hff), "acmd41", got);
      end
      check_state(link_card_state, card_ready, "after acmd41");
      send_cmd(6'd2, 32'h0, 1'b1);
      expect_resp(resp_r2, {2'b00, 6'h3f, default_cid[127:1], 1'b1}, "cmd2", got);
      check_state(link_card_state, card_ident, "after cmd2");
      sw = status_word(card_ident, 1'b0);
      send_cmd(6'd3, 32'h0, 1'b1);
      expect_resp(resp_r6, short_frame(6'd3, {16'h1337, sw[23:22], sw[19], sw[12:0]}, 8'h01),
                  "cmd3", got);
      check_state(link_card_state, card_stby, "after cmd3");
   endtask

   task automatic test_select;
      logic [resp_frame_w-1:0] got;
      send_cmd(6'd7, {16'h1337, 16'h0}, 1'b1);
      expect_resp(resp_r1b, short_frame(6'd7, status_word(card_stby, 1'b0), 8'h01), "cmd7", got);
      check_state(link_card_state, card_tran, "after cmd7");
      send_cmd(6'd55, {16'h1337, 16'h0}, 1'b1);
      expect_resp(resp_r1, short_frame(6'd55, status_word(card_tran, 1'b1), 8'h01),
                  "cmd55 in tran", got);
      send_cmd(6'd6, 32'h0000_0002, 1'b1);
      expect_resp(resp_r1, short_frame(6'd6, status_word(card_tran, 1'b1), 8'h01), "acmd6", got);
      check_bit(phy_mode_4bit, 1'b1, "4-bit mode after acmd6");
   endtask

   task automatic test_status;
      logic [resp_frame_w-1:0] got;
      logic [31:0]             st;
      send_cmd(6'd13, {16'h1337, 16'h0}, 1'b1);
      expect_resp(resp_r1, short_frame(6'd13, status_word(card_tran, 1'b0), 8'h01), "cmd13", got);
      st = got[127:96];
      check_state(card_state_e'(st[12:9]), card_tran, "cmd13 current state field");
      check_bit(st[stat_app_cmd], 1'b0, "cmd13 app_cmd bit");
      send_cmd(6'd13, 32'h0001_0000, 1'b1);
      expect_no_resp("cmd13 with wrong rca");
   endtask

   task automatic test_errors;
      logic [resp_frame_w-1:0] got;
      logic [31:0]             sw;
      send_cmd(6'd13, {16'h1337, 16'h0}, 1'b0);
      expect_no_resp("command with bad crc");
      check_bit(err_cmd_crc, 1'b1, "crc error flag");
      send_cmd(6'd60, 32'h0, 1'b1);
      expect_no_resp("unknown cmd60");
      check_bit(err_unhandled_cmd, 1'b1, "unhandled command flag");
      check_index(cmd_in_last, 6'd60, "last index after cmd60");
      send_cmd(6'd2, 32'h0, 1'b1);
      expect_no_resp("cmd2 in tran");
      check_state(link_card_state, card_tran, "state after illegal cmd2");
      // both error bits ride on the next answered command
      sw = status_word(card_tran, 1'b0) | (32'd1 << stat_com_crc_error) |
           (32'd1 << stat_illegal_command);
      send_cmd(6'd13, {16'h1337, 16'h0}, 1'b1);
      expect_resp(resp_r1, short_frame(6'd13, sw, 8'h01), "cmd13 after errors", got);
   endtask

   initial begin
      repeat (watchdog_cycles) @(posedge clk_50);
      $display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      seed                = 32'h11387891;
      mismatch_count      = 0;
      failure_count       = 0;
      clk_50              = 1'b0;
      reset_s             = 1'b0;
      phy_cmd_in          = '0;
      phy_cmd_in_crc_good = 1'b0;
      phy_cmd_in_act      = 1'b0;
      phy_resp_done       = 1'b0;
      repeat (2) @(posedge clk_50);
      #5;
      reset_s = 1'b1;
      test_reset();
      // let the synchronizers settle
      repeat (4) wait_cycle();
      test_init();
      test_select();
      test_status();
      test_errors();
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
      if (mismatch_count == 0 && failure_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- verilog/sd_cmd_capture.sv
`timescale 1ns/1ns
// command capture stage: CRC check and a one-command holding register
module sd_cmd_capture (
   input  logic                 clk_50,
   input  logic                 reset_s,
   input  logic [47:0]          phy_cmd_in,
   input  logic                 phy_cmd_in_crc_good,
   input  logic                 phy_cmd_in_act,
   input  logic                 take,
   output logic                 pending,
   output sd_link_pkg::sd_cmd_t cmd,
   output logic                 err_cmd_crc,
   output logic                 crc_error
);

   logic crc_good_s;
   logic act_rise;

   sd_edge_sync u_crc_sync (
      .clk_50 (clk_50),
      .d      (phy_cmd_in_crc_good),
      .q      (crc_good_s),
      .rise   ()
   );

   sd_edge_sync u_act_sync (
      .clk_50 (clk_50),
      .d      (phy_cmd_in_act),
      .q      (),
      .rise   (act_rise)
   );

   // the phy holds the frame stable while act is up
   always_ff @(posedge clk_50) begin
      crc_error <= 1'b0;
      if (take) begin
         pending <= 1'b0;
      end
      if (act_rise) begin
         if (crc_good_s) begin
            cmd.index <= phy_cmd_in[45:40];
            cmd.arg   <= phy_cmd_in[39:8];
            pending   <= 1'b1;
         end else begin
            err_cmd_crc <= 1'b1;
            crc_error   <= 1'b1;
         end
      end
      if (!reset_s) begin
         pending     <= 1'b0;
         err_cmd_crc <= 1'b0;
         crc_error   <= 1'b0;
      end
   end

   // execute only takes a command that is actually held
   a_take_needs_pending: assert property (@(posedge clk_50) disable iff (!reset_s)
      take |-> pending);

endmodule

//--- verilog/sd_cmd_exec.sv
`timescale 1ns/1ns
// command execute stage: card FSM, status register, RCA, OCR and app-command handling
module sd_cmd_exec #(
   parameter int acmd41_polls = 3
) (
   input  logic                     clk_50,
   input  logic                     reset_s,
   input  logic                     pending,
   input  sd_link_pkg::sd_cmd_t     cmd,
   output logic                     take,
   input  logic                     crc_error,
   input  logic                     resp_sent,
   output logic                     req_valid,
   output sd_link_pkg::resp_req_t   req,
   output sd_link_pkg::card_state_e card_state,
   output logic                     mode_4bit,
   output logic [5:0]               cmd_in_last,
   output logic                     err_unhandled_cmd
);
   import sd_link_pkg::*;

   typedef enum logic [1:0] {st_idle, st_decode, st_status, st_wait} stage_e;

   stage_e       stage;
   sd_cmd_t      cmd_q;
   card_state_e  state_next;
   resp_kind_e   kind;
   logic [127:0] payload;
   logic [31:0]  status;
   logic [15:0]  rca;
   logic [31:0]  ocr;
   logic [7:0]   poll_count;
   logic         appcmd;
   logic         rca_hit;
   logic         go_idle;

   assign take    = (stage == st_idle) && pending;
   assign rca_hit = (cmd_q.arg[31:16] == rca);
   // CMD0 outside ina returns all card registers to power-up values
   assign go_idle = (stage == st_decode) && !appcmd && (cmd_q.index == cmd0_go_idle) &&
                    (card_state != card_ina);

   always_ff @(posedge clk_50) begin
      req_valid <= 1'b0;
      case (stage)
      st_idle: if (take) begin
         cmd_q       <= cmd;
         cmd_in_last <= cmd.index;
         stage       <= st_decode;
      end
      st_decode: begin
         // anything not matched below is illegal in this state
         stage      <= st_status;
         kind       <= resp_bad;
         state_next <= card_state;
         payload    <= '0;
         if (!appcmd) begin
            case (cmd_q.index)
            cmd0_go_idle: if (card_state != card_ina) begin
               kind       <= resp_none;
               state_next <= card_idle;
            end
            cmd2_all_send_cid: if (card_state == card_ready) begin
               kind       <= resp_r2;
               payload    <= default_cid;
               state_next <= card_ident;
            end
            cmd3_send_rel_addr: if (card_state inside {card_ident, card_stby}) begin
               rca           <= rca + rca_step;
               payload[15:0] <= rca + rca_step;
               kind          <= resp_r6;
               state_next    <= card_stby;
            end
            cmd7_sel_card: if (rca_hit) begin
               if (card_state inside {card_stby, card_dis}) begin
                  kind       <= resp_r1b;
                  state_next <= card_tran;
               end
            end else begin
               // deselect, never answered
               kind <= resp_none;
               if (card_state inside {card_tran, card_data}) begin
                  state_next <= card_stby;
               end else if (card_state == card_prg) begin
                  state_next <= card_dis;
               end
            end
            cmd8_send_if_cond: if (card_state == card_idle) begin
               if (cmd_q.arg[11:8] == 4'h1) begin
                  kind          <= resp_r7;
                  payload[11:0] <= cmd_q.arg[11:0];
               end else begin
                  kind <= resp_none;
               end
            end
            cmd9_send_csd, cmd10_send_cid: if (!rca_hit) begin
               kind <= resp_none;
            end else if (card_state == card_stby) begin
               kind    <= resp_r2;
               payload <= (cmd_q.index == cmd9_send_csd) ? default_csd : default_cid;
            end
            cmd13_send_status: if (!rca_hit) begin
               kind <= resp_none;
            end else if (card_state inside {[card_stby:card_dis]}) begin
               kind <= resp_r1;
            end
            cmd55_app_cmd: if (!rca_hit) begin
               kind <= resp_none;
            end else if (card_state inside {card_idle, [card_stby:card_dis]}) begin
               kind                 <= resp_r1;
               appcmd               <= 1'b1;
               status[stat_app_cmd] <= 1'b1;
            end
            default: err_unhandled_cmd <= 1'b1;
            endcase
         end else begin
            case (cmd_q.index)
            acmd6_set_bus_width: if (card_state == card_tran) begin
               kind      <= resp_r1;
               mode_4bit <= cmd_q.arg[1];
            end
            acmd41_send_op_cond: if (card_state == card_idle) begin
               kind          <= resp_r3;
               payload[31:0] <= ocr;
               if (poll_count != 8'hff) begin
                  poll_count <= poll_count + 8'd1;
               end
               // host must accept high capacity and offer a voltage window
               if (cmd_q.arg[30] && (cmd_q.arg[23:0] != 24'h0) &&
                   (poll_count >= 8'(acmd41_polls))) begin
                  ocr[ocr_powered_up]     <= 1'b1;
                  payload[ocr_powered_up] <= 1'b1;
                  state_next              <= card_ready;
               end
            end
            // unknown ACMD, decode again as a standard command
            default: begin
               appcmd <= 1'b0;
               stage  <= st_decode;
            end
            endcase
         end
      end
      st_status: begin
         if (kind == resp_bad) begin
            status[stat_illegal_command] <= 1'b1;
         end
         req.kind    <= kind;
         req.index   <= cmd_q.index;
         req.status  <= {status[31:13], card_state, status[8:0]};
         req.payload <= payload;
         req_valid   <= 1'b1;
         stage       <= st_wait;
      end
      st_wait: if (resp_sent) begin
         card_state <= state_next;
         if (appcmd && (cmd_q.index != cmd55_app_cmd)) begin
            appcmd               <= 1'b0;
            status[stat_app_cmd] <= 1'b0;
         end
         if (cmd_q.index == cmd13_send_status) begin
            status <= status & ~stat_clear_on_read;
         end
         // error bits stay until a response has carried them
         if ((kind != resp_none) && (kind != resp_bad)) begin
            status[stat_com_crc_error]   <= 1'b0;
            status[stat_illegal_command] <= 1'b0;
         end
         stage <= st_idle;
      end
      default: stage <= st_idle;
      endcase

      if (crc_error) begin
         status[stat_com_crc_error] <= 1'b1;
      end

      if (!reset_s || go_idle) begin
         card_state <= card_idle;
         status     <= status_default;
         rca        <= 16'h0;
         ocr        <= ocr_default;
         poll_count <= 8'd0;
         appcmd     <= 1'b0;
         mode_4bit  <= 1'b0;
      end
      if (!reset_s) begin
         stage             <= st_idle;
         req_valid         <= 1'b0;
         err_unhandled_cmd <= 1'b0;
      end
   end

   // the builder only completes a request that execute is waiting on
   a_sent_in_wait: assert property (@(posedge clk_50) disable iff (!reset_s)
      resp_sent |-> stage == st_wait);

   // the card leaves idle only after ACMD41 has set the powered-up bit
   a_left_idle_powered: assert property (@(posedge clk_50) disable iff (!reset_s)
      card_state != card_idle |-> ocr[ocr_powered_up]);

endmodule

//--- verilog/sd_edge_sync.sv
`timescale 1ns/1ns
// three-stage synchronizer with a rising-edge pulse on bit 0
module sd_edge_sync #(
   parameter int sync_width = 1
) (
   input  logic                  clk_50,
   input  logic [sync_width-1:0] d,
   output logic [sync_width-1:0] q,
   output logic                  rise
);

   logic [sync_width-1:0] meta;
   logic [sync_width-1:0] stage2;
   logic [sync_width-1:0] stage3;

   always_ff @(posedge clk_50) begin
      meta   <= d;
      stage2 <= meta;
      stage3 <= stage2;
   end

   // high in the cycle the last stage turns from 0 to 1
   always_ff @(posedge clk_50) begin
      rise <= stage2[0] & ~stage3[0];
   end

   assign q = stage3;

endmodule

//--- verilog/sd_link.sv
`timescale 1ns/1ns
// SD link top level: capture, execute and response build stages
module sd_link #(
   parameter int acmd41_polls = 3
) (
   input  logic                                 clk_50,
   input  logic                                 reset_s,
   input  logic [47:0]                          phy_cmd_in,
   input  logic                                 phy_cmd_in_crc_good,
   input  logic                                 phy_cmd_in_act,
   input  logic                                 phy_resp_done,
   output logic [sd_link_pkg::resp_frame_w-1:0] phy_resp_out,
   output sd_link_pkg::resp_kind_e              phy_resp_type,
   output logic                                 phy_resp_busy,
   output logic                                 phy_resp_act,
   output logic                                 phy_mode_4bit,
   output sd_link_pkg::card_state_e             link_card_state,
   output logic [5:0]                           cmd_in_last,
   output logic                                 err_cmd_crc,
   output logic                                 err_unhandled_cmd
);
   import sd_link_pkg::*;

   sd_cmd_t   cmd;
   resp_req_t req;
   logic      pending;
   logic      take;
   logic      crc_error;
   logic      req_valid;
   logic      resp_sent;

   sd_cmd_capture u_capture (
      .clk_50              (clk_50),
      .reset_s             (reset_s),
      .phy_cmd_in          (phy_cmd_in),
      .phy_cmd_in_crc_good (phy_cmd_in_crc_good),
      .phy_cmd_in_act      (phy_cmd_in_act),
      .take                (take),
      .pending             (pending),
      .cmd                 (cmd),
      .err_cmd_crc         (err_cmd_crc),
      .crc_error           (crc_error)
   );

   sd_cmd_exec #(
      .acmd41_polls (acmd41_polls)
   ) u_exec (
      .clk_50            (clk_50),
      .reset_s           (reset_s),
      .pending           (pending),
      .cmd               (cmd),
      .take              (take),
      .crc_error         (crc_error),
      .resp_sent         (resp_sent),
      .req_valid         (req_valid),
      .req               (req),
      .card_state        (link_card_state),
      .mode_4bit         (phy_mode_4bit),
      .cmd_in_last       (cmd_in_last),
      .err_unhandled_cmd (err_unhandled_cmd)
   );

   sd_resp_builder u_resp (
      .clk_50        (clk_50),
      .reset_s       (reset_s),
      .req_valid     (req_valid),
      .req           (req),
      .phy_resp_done (phy_resp_done),
      .resp_sent     (resp_sent),
      .phy_resp_out  (phy_resp_out),
      .phy_resp_type (phy_resp_type),
      .phy_resp_busy (phy_resp_busy),
      .phy_resp_act  (phy_resp_act)
   );

endmodule

//--- verilog/sd_link_pkg.sv
// shared SD link types: state, command and response enums, frame structs, status bits, defaults
package sd_link_pkg;

   // card states as reported in status bits 12:9
   typedef enum logic [3:0] {
      card_idle  = 4'd0,
      card_ready = 4'd1,
      card_ident = 4'd2,
      card_stby  = 4'd3,
      card_tran  = 4'd4,
      card_data  = 4'd5,
      card_rcv   = 4'd6,
      card_prg   = 4'd7,
      card_dis   = 4'd8,
      card_ina   = 4'd15
   } card_state_e;

   // app commands reuse the index space, told apart by the app-command flag
   typedef enum logic [5:0] {
      cmd0_go_idle        = 6'd0,
      cmd2_all_send_cid   = 6'd2,
      cmd3_send_rel_addr  = 6'd3,
      acmd6_set_bus_width = 6'd6,
      cmd7_sel_card       = 6'd7,
      cmd8_send_if_cond   = 6'd8,
      cmd9_send_csd       = 6'd9,
      cmd10_send_cid      = 6'd10,
      cmd13_send_status   = 6'd13,
      acmd41_send_op_cond = 6'd41,
      cmd55_app_cmd       = 6'd55
   } sd_cmd_e;

   typedef enum logic [3:0] {
      resp_none = 4'd0,
      resp_bad  = 4'd1,
      resp_r1   = 4'd2,
      resp_r1b  = 4'd3,
      resp_r2   = 4'd4,
      resp_r3   = 4'd5,
      resp_r6   = 4'd6,
      resp_r7   = 4'd7
   } resp_kind_e;

   typedef struct packed {
      logic [5:0]  index;
      logic [31:0] arg;
   } sd_cmd_t;

   // payload holds CID, CSD, OCR, the new RCA or the R7 echo
   typedef struct packed {
      resp_kind_e   kind;
      logic [5:0]   index;
      logic [31:0]  status;
      logic [127:0] payload;
   } resp_req_t;

   // card status bit positions
   localparam int stat_out_of_range       = 31;
   localparam int stat_address_error      = 30;
   localparam int stat_block_len_error    = 29;
   localparam int stat_erase_seq_error    = 28;
   localparam int stat_erase_param        = 27;
   localparam int stat_wp_violation       = 26;
   localparam int stat_lock_unlock_failed = 24;
   localparam int stat_com_crc_error      = 23;
   localparam int stat_illegal_command    = 22;
   localparam int stat_card_ecc_failed    = 21;
   localparam int stat_cc_error           = 20;
   localparam int stat_csd_overwrite      = 16;
   localparam int stat_wp_erase_skip      = 15;
   localparam int stat_erase_reset        = 13;
   localparam int stat_ready_for_data     = 8;
   localparam int stat_app_cmd            = 5;
   localparam int stat_ake_seq_error      = 3;

   // bits that a CMD13 read clears
   localparam logic [31:0] stat_clear_on_read =
      (32'd1 << stat_out_of_range) | (32'd1 << stat_address_error) |
      (32'd1 << stat_block_len_error) | (32'd1 << stat_erase_seq_error) |
      (32'd1 << stat_erase_param) | (32'd1 << stat_wp_violation) |
      (32'd1 << stat_lock_unlock_failed) | (32'd1 << stat_card_ecc_failed) |
      (32'd1 << stat_cc_error) | (32'd1 << stat_csd_overwrite) |
      (32'd1 << stat_wp_erase_skip) | (32'd1 << stat_erase_reset) |
      (32'd1 << stat_app_cmd) | (32'd1 << stat_ake_seq_error);

   localparam logic [31:0] status_default = 32'd1 << stat_ready_for_data;

   // mid, oid, pnm, prv, psn, reserved, mdt, crc slot
   localparam logic [127:0] default_cid = {8'h5a, 16'h4c4b, 40'h4c494e4b31, 8'h10,
                                           32'h0000_1337, 4'h0, 12'h131, 8'hff};

   // CSD v2.0 for a high-capacity card
   localparam logic [127:0] default_csd = {2'b01, 6'h0, 8'h0e, 8'h00, 8'h32, 12'h5b5,
                                           4'h9, 1'b0, 1'b0, 1'b0, 1'b0, 6'h0,
                                           22'h001dff, 1'b0, 1'b1, 7'h7f, 7'h00, 1'b0,
                                           2'b00, 3'b010, 4'h9, 1'b0, 5'h0, 1'b0,
                                           1'b0, 1'b0, 1'b0, 2'b00, 2'h0, 8'hff};

   localparam logic [23:0] ocr_voltage_window = 24'hff8000;
   localparam int          ocr_powered_up     = 31;
   // high capacity set, not yet powered up
   localparam logic [31:0] ocr_default        = {8'h40, ocr_voltage_window};

   localparam logic [15:0] rca_step     = 16'h1337;
   localparam int          resp_frame_w = 136;

endpackage

//--- verilog/sd_resp_builder.sv
`timescale 1ns/1ns
// response build stage: frame formatting and the response handshake to the phy
module sd_resp_builder (
   input  logic                                   clk_50,
   input  logic                                   reset_s,
   input  logic                                   req_valid,
   input  sd_link_pkg::resp_req_t                 req,
   input  logic                                   phy_resp_done,
   output logic                                   resp_sent,
   output logic [sd_link_pkg::resp_frame_w-1:0]   phy_resp_out,
   output sd_link_pkg::resp_kind_e                phy_resp_type,
   output logic                                   phy_resp_busy,
   output logic                                   phy_resp_act
);
   import sd_link_pkg::*;

   logic                    done_rise;
   logic                    no_resp;
   logic                    sent_q;
   logic [resp_frame_w-1:0] frame;

   sd_edge_sync u_done_sync (
      .clk_50 (clk_50),
      .d      (phy_resp_done),
      .q      (),
      .rise   (done_rise)
   );

   // none and bad finish at once, nothing goes on the line
   assign no_resp   = (req.kind == resp_none) || (req.kind == resp_bad);
   assign resp_sent = sent_q || (req_valid && no_resp);

   always_comb begin
      case (req.kind)
      resp_r1, resp_r1b: frame = {2'b00, req.index, req.status, 8'h01, 88'h0};
      resp_r2:           frame = {2'b00, 6'h3f, req.payload[127:1], 1'b1};
      resp_r3:           frame = {2'b00, 6'h3f, req.payload[31:0], 8'hff, 88'h0};
      // compressed status: bits 23, 22, 19 and 12:0
      resp_r6:           frame = {2'b00, 6'd3, req.payload[15:0], req.status[23:22],
                                  req.status[19], req.status[12:0], 8'h01, 88'h0};
      resp_r7:           frame = {2'b00, 6'd8, req.payload[31:0], 8'h01, 88'h0};
      default:           frame = '0;
      endcase
   end

   always_ff @(posedge clk_50) begin
      sent_q <= 1'b0;
      if (req_valid && !no_resp) begin
         phy_resp_out  <= frame;
         phy_resp_type <= req.kind;
         phy_resp_busy <= (req.kind == resp_r1b);
         phy_resp_act  <= 1'b1;
      end else if (phy_resp_act && done_rise) begin
         phy_resp_act  <= 1'b0;
         phy_resp_busy <= 1'b0;
         sent_q        <= 1'b1;
      end
      if (!reset_s) begin
         phy_resp_act  <= 1'b0;
         phy_resp_busy <= 1'b0;
         sent_q        <= 1'b0;
      end
   end

   a_no_act_silent: assert property (@(posedge clk_50) disable iff (!reset_s)
      (req_valid && no_resp) |=> !phy_resp_act);

endmodule
